/* src/cpuPkg.sv */
package cpuPkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;
   typedef logic [15:0] imemAddr_t;
   typedef logic [15:0] dmemAddr_t;

   localparam int NUM_REGS = 8;

   // instruction bits 15 to 12, every other code is illegal
   typedef enum logic [3:0] {
      NOP  = 4'h0,
      ADD  = 4'h1,
      SUB  = 4'h2,
      AND  = 4'h3,
      XOR  = 4'h4,
      ADDI = 4'h5,
      LBI  = 4'h6,
      LD   = 4'h7,
      ST   = 4'h8,
      BEQZ = 4'h9,
      HALT = 4'hA
   } opcode_t;

   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_HI  = 11;
   localparam int RD_LO  = 9;
   localparam int RS_HI  = 8;
   localparam int RS_LO  = 6;
   localparam int RT_HI  = 5;
   localparam int RT_LO  = 3;

   // imm6 sits in bits 5 to 0, imm8 in bits 7 to 0
   function automatic word_t signExt6(word_t instr);
      return {{10{instr[5]}}, instr[5:0]};
   endfunction

   function automatic word_t signExt8(word_t instr);
      return {{8{instr[7]}}, instr[7:0]};
   endfunction

endpackage

/* src/pipePkg.sv */
package pipePkg;
   import cpuPkg::*;

   typedef struct packed {
      logic      valid;
      imemAddr_t addr;
      word_t     instr;
   } progWrite_t;

   typedef struct packed {
      logic      valid;
      imemAddr_t pcPlusOne;
      word_t     instr;
   } fdReg_t;

   typedef enum logic [2:0] {
      ALU_PASSB,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } aluOp_t;

   // srcA is rs, srcB is rt, srcC is rd (store data or branch test)
   typedef struct packed {
      logic      valid;
      aluOp_t    aluOp;
      word_t     opA;
      word_t     opB;
      word_t     storeData;
      regIdx_t   srcA;
      regIdx_t   srcB;
      regIdx_t   srcC;
      word_t     imm;
      logic      immSel;
      logic      memRead;
      logic      memWrite;
      logic      regWrite;
      regIdx_t   dest;
      logic      isBranch;
      logic      isHalt;
      logic      illegal;
      imemAddr_t pcPlusOne;
   } dxReg_t;

   typedef struct packed {
      logic    valid;
      word_t   aluResult;
      word_t   storeData;
      logic    memRead;
      logic    memWrite;
      logic    regWrite;
      regIdx_t dest;
      logic    isHalt;
      logic    illegal;
   } xmReg_t;

   typedef struct packed {
      logic    valid;
      regIdx_t dest;
      word_t   data;
      logic    isHalt;
      logic    illegal;
   } retire_t;

   typedef struct packed {
      logic      taken;
      imemAddr_t target;
   } redirect_t;

   // halt and illegal records retire without touching the register file
   function automatic logic retireWrites(retire_t r);
      return r.valid && !r.isHalt && !r.illegal;
   endfunction

endpackage

/* src/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage
   import cpuPkg::*, pipePkg::*;
#(
   parameter int IMEM_DEPTH = 256
) (
   input  logic       clk,
   input  logic       arstN,
   input  logic       run,
   input  progWrite_t progWrite,
   input  logic       stall,
   input  logic       haltSeen,
   input  redirect_t  redirect,
   output fdReg_t     fd
);

   localparam int ADDR_W = $clog2(IMEM_DEPTH);

   word_t     imem [IMEM_DEPTH];
   imemAddr_t pc;

   // program load port, written only while the core is idle
   always_ff @(posedge clk) begin
      if (progWrite.valid) begin
         imem[progWrite.addr[ADDR_W-1:0]] <= progWrite.instr;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
         fd <= '0;
      end else if (redirect.taken) begin
         // taken branch kills whatever is being fetched now
         pc       <= redirect.target;
         fd.valid <= 1'b0;
      end else if (!run) begin
         pc       <= '0;
         fd.valid <= 1'b0;
      end else if (!stall) begin
         if (haltSeen) begin
            fd.valid <= 1'b0;
         end else begin
            fd.valid     <= 1'b1;
            fd.instr     <= imem[pc[ADDR_W-1:0]];
            fd.pcPlusOne <= pc + 16'd1;
            pc           <= pc + 16'd1;
         end
      end
   end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage
   import cpuPkg::*, pipePkg::*;
(
   input  logic      clk,
   input  logic      arstN,
   input  fdReg_t    fd,
   input  retire_t   retire,
   input  redirect_t redirect,
   output logic      stall,
   output logic      haltSeen,
   output dxReg_t    dx
);

   word_t   regFile [NUM_REGS];
   opcode_t opcode;
   regIdx_t rd;
   regIdx_t rs;
   regIdx_t rt;
   word_t   rdVal;
   word_t   rsVal;
   word_t   rtVal;
   logic    wbWrite;
   logic    useRs;
   logic    useRt;
   logic    useRd;
   logic    haltLatch;
   dxReg_t  dxNext;

   assign opcode = opcode_t'(fd.instr[OPC_HI:OPC_LO]);
   assign rd     = fd.instr[RD_HI:RD_LO];
   assign rs     = fd.instr[RS_HI:RS_LO];
   assign rt     = fd.instr[RT_HI:RT_LO];

   // writeback data bypasses into a same-cycle read
   assign wbWrite = retireWrites(retire);
   assign rdVal   = (wbWrite && retire.dest == rd) ? retire.data : regFile[rd];
   assign rsVal   = (wbWrite && retire.dest == rs) ? retire.data : regFile[rs];
   assign rtVal   = (wbWrite && retire.dest == rt) ? retire.data : regFile[rt];

   always_comb begin
      dxNext           = '0;
      useRs            = 1'b0;
      useRt            = 1'b0;
      useRd            = 1'b0;
      dxNext.valid     = fd.valid;
      dxNext.aluOp     = ALU_PASSB;
      dxNext.opA       = rsVal;
      dxNext.opB       = rtVal;
      dxNext.storeData = rdVal;
      dxNext.srcA      = rs;
      dxNext.srcB      = rt;
      dxNext.srcC      = rd;
      dxNext.dest      = rd;
      dxNext.pcPlusOne = fd.pcPlusOne;
      case (opcode)
         NOP: ;
         ADD, SUB, AND, XOR: begin
            useRs           = 1'b1;
            useRt           = 1'b1;
            dxNext.regWrite = 1'b1;
            dxNext.aluOp    = (opcode == ADD) ? ALU_ADD :
                              (opcode == SUB) ? ALU_SUB :
                              (opcode == AND) ? ALU_AND : ALU_XOR;
         end
         ADDI, LD, ST: begin
            // all three add a 6-bit offset to rs
            useRs           = 1'b1;
            useRd           = (opcode == ST);
            dxNext.aluOp    = ALU_ADD;
            dxNext.immSel   = 1'b1;
            dxNext.imm      = signExt6(fd.instr);
            dxNext.memRead  = (opcode == LD);
            dxNext.memWrite = (opcode == ST);
            dxNext.regWrite = (opcode != ST);
         end
         LBI: begin
            dxNext.immSel   = 1'b1;
            dxNext.imm      = signExt8(fd.instr);
            dxNext.regWrite = 1'b1;
         end
         BEQZ: begin
            useRd           = 1'b1;
            dxNext.isBranch = 1'b1;
            dxNext.imm      = signExt8(fd.instr);
         end
         HALT:    dxNext.isHalt  = 1'b1;
         default: dxNext.illegal = 1'b1;
      endcase
   end

   // load in execute feeding this instruction costs one bubble
   assign stall = dx.valid && dx.memRead && fd.valid &&
                  ((useRs && dx.dest == rs) || (useRt && dx.dest == rt) ||
                   (useRd && dx.dest == rd));

   assign haltSeen = haltLatch || (fd.valid && opcode == HALT);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regFile[i] <= '0;
         end
      end else if (wbWrite) begin
         regFile[retire.dest] <= retire.data;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dx        <= '0;
         haltLatch <= 1'b0;
      end else if (redirect.taken || stall) begin
         dx <= '0;
      end else begin
         dx <= dxNext;
         if (fd.valid && opcode == HALT) begin
            haltLatch <= 1'b1;
         end
      end
   end

endmodule

/* src/executeStage.sv */
`timescale 1ns/1ps

module executeStage
   import cpuPkg::*, pipePkg::*;
(
   input  logic      clk,
   input  logic      arstN,
   input  dxReg_t    dx,
   input  retire_t   wbFwd,
   output xmReg_t    xm,
   output redirect_t redirect
);

   word_t  opA;
   word_t  opB;
   word_t  stData;
   word_t  aluResult;
   xmReg_t xmNext;

   // newest producer wins, a load in memory is not ready yet
   function automatic word_t forward(
      regIdx_t idx,
      word_t   regVal,
      xmReg_t  memSrc,
      retire_t wbSrc
   );
      if (memSrc.valid && memSrc.regWrite && !memSrc.memRead && memSrc.dest == idx) begin
         return memSrc.aluResult;
      end
      if (retireWrites(wbSrc) && wbSrc.dest == idx) begin
         return wbSrc.data;
      end
      return regVal;
   endfunction

   assign opA    = forward(dx.srcA, dx.opA, xm, wbFwd);
   assign opB    = dx.immSel ? dx.imm : forward(dx.srcB, dx.opB, xm, wbFwd);
   assign stData = forward(dx.srcC, dx.storeData, xm, wbFwd);

   always_comb begin
      case (dx.aluOp)
         ALU_ADD: aluResult = opA + opB;
         ALU_SUB: aluResult = opA - opB;
         ALU_AND: aluResult = opA & opB;
         ALU_XOR: aluResult = opA ^ opB;
         default: aluResult = opB;
      endcase
   end

   // BEQZ tests rd, target is relative to the next PC
   assign redirect.taken  = dx.valid && dx.isBranch && (stData == '0);
   assign redirect.target = dx.pcPlusOne + dx.imm;

   always_comb begin
      xmNext.valid     = dx.valid;
      xmNext.aluResult = aluResult;
      xmNext.storeData = stData;
      xmNext.memRead   = dx.memRead;
      xmNext.memWrite  = dx.memWrite;
      xmNext.regWrite  = dx.regWrite;
      xmNext.dest      = dx.dest;
      xmNext.isHalt    = dx.isHalt;
      xmNext.illegal   = dx.illegal;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         xm <= '0;
      end else begin
         xm <= xmNext;
      end
   end

endmodule

/* src/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage
   import cpuPkg::*, pipePkg::*;
#(
   parameter int DMEM_DEPTH = 256
) (
   input  logic    clk,
   input  logic    arstN,
   input  xmReg_t  xm,
   output retire_t retire,
   output logic    halted,
   output logic    err
);

   localparam int ADDR_W = $clog2(DMEM_DEPTH);

   word_t     dmem [DMEM_DEPTH];
   dmemAddr_t addr;
   word_t     loaded;

   assign addr   = xm.aluResult;
   assign loaded = dmem[addr[ADDR_W-1:0]];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (xm.valid && xm.memWrite) begin
         dmem[addr[ADDR_W-1:0]] <= xm.storeData;
      end
   end

   // stores, branches and NOPs leave no retire record
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         retire <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         retire.valid   <= xm.valid && (xm.regWrite || xm.isHalt || xm.illegal);
         retire.dest    <= xm.regWrite ? xm.dest : '0;
         retire.data    <= !xm.regWrite ? '0 : (xm.memRead ? loaded : xm.aluResult);
         retire.isHalt  <= xm.isHalt;
         retire.illegal <= xm.illegal;
         halted         <= halted || (xm.valid && xm.isHalt);
         err            <= err || (xm.valid && xm.illegal);
      end
   end

endmodule

/* src/pipeCore.sv */
`timescale 1ns/1ps

module pipeCore
   import pipePkg::*;
#(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  logic       clk,
   input  logic       arstN,
   input  logic       run,
   input  progWrite_t progWrite,
   output retire_t    retire,
   output logic       halted,
   output logic       err
);

   fdReg_t    fd;
   dxReg_t    dx;
   xmReg_t    xm;
   redirect_t redirect;
   logic      stall;
   logic      haltSeen;

   fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (
      .clk(clk), .arstN(arstN), .run(run), .progWrite(progWrite),
      .stall(stall), .haltSeen(haltSeen), .redirect(redirect), .fd(fd)
   );

   // retire doubles as the register file write port
   decodeStage i_decode (
      .clk(clk), .arstN(arstN), .fd(fd), .retire(retire), .redirect(redirect),
      .stall(stall), .haltSeen(haltSeen), .dx(dx)
   );

   executeStage i_execute (
      .clk(clk), .arstN(arstN), .dx(dx), .wbFwd(retire),
      .xm(xm), .redirect(redirect)
   );

   memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) i_memory (
      .clk(clk), .arstN(arstN), .xm(xm),
      .retire(retire), .halted(halted), .err(err)
   );

endmodule

/* include/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// reference model state, steps a program one instruction at a time
cpuPkg::word_t    regs [cpuPkg::NUM_REGS];
cpuPkg::word_t    dmem [int];
pipePkg::retire_t expQ [$];

// offsets and byte immediates are two's complement
function automatic cpuPkg::word_t imm6Of(cpuPkg::word_t instr);
   return 16'($signed(instr[5:0]));
endfunction

function automatic cpuPkg::word_t imm8Of(cpuPkg::word_t instr);
   return 16'($signed(instr[7:0]));
endfunction

function automatic void pushRec(cpuPkg::regIdx_t rd, cpuPkg::word_t data, bit halt, bit bad);
   pipePkg::retire_t rec;
   rec         = '0;
   rec.valid   = 1'b1;
   rec.isHalt  = halt;
   rec.illegal = bad;
   if (!halt && !bad) begin
      regs[rd]  = data;
      rec.dest  = rd;
      rec.data  = data;
   end
   expQ.push_back(rec);
endfunction

function automatic void runModel(cpuPkg::word_t image [], int dmemDepth, int maxSteps = 2000);
   cpuPkg::word_t     instr;
   cpuPkg::word_t     a;
   cpuPkg::word_t     b;
   cpuPkg::word_t     d;
   cpuPkg::imemAddr_t pc;
   cpuPkg::opcode_t   opc;
   int                addr;
   int                dmemMask;
   bit                done;
   pc       = '0;
   done     = 1'b0;
   dmemMask = dmemDepth - 1;
   dmem.delete();
   expQ.delete();
   foreach (regs[i]) begin
      regs[i] = '0;
   end
   for (int step = 0; step < maxSteps && !done; step++) begin
      instr = (pc < image.size()) ? image[pc] : '0;
      opc   = cpuPkg::opcode_t'(instr[cpuPkg::OPC_HI:cpuPkg::OPC_LO]);
      d     = regs[instr[cpuPkg::RD_HI:cpuPkg::RD_LO]];
      a     = regs[instr[cpuPkg::RS_HI:cpuPkg::RS_LO]];
      b     = regs[instr[cpuPkg::RT_HI:cpuPkg::RT_LO]];
      addr  = (a + imm6Of(instr)) & dmemMask;
      pc    = pc + 16'd1;
      case (opc)
         cpuPkg::NOP: ;
         cpuPkg::ADD:  pushRec(instr[11:9], a + b, 0, 0);
         cpuPkg::SUB:  pushRec(instr[11:9], a - b, 0, 0);
         cpuPkg::AND:  pushRec(instr[11:9], a & b, 0, 0);
         cpuPkg::XOR:  pushRec(instr[11:9], a ^ b, 0, 0);
         cpuPkg::ADDI: pushRec(instr[11:9], a + imm6Of(instr), 0, 0);
         cpuPkg::LBI:  pushRec(instr[11:9], imm8Of(instr), 0, 0);
         cpuPkg::LD:   pushRec(instr[11:9], dmem.exists(addr) ? dmem[addr] : '0, 0, 0);
         cpuPkg::ST:   dmem[addr] = d;
         cpuPkg::BEQZ: pc = (d == '0) ? pc + imm8Of(instr) : pc;
         cpuPkg::HALT: begin
            pushRec('0, '0, 1, 0);
            done = 1'b1;
         end
         default: pushRec('0, '0, 0, 1);
      endcase
   end
endfunction

`endif

/* verification/pipeCoreTb.sv */
`timescale 1ns/1ps

module pipeCoreTb
   import cpuPkg::*, pipePkg::*;
();

   localparam int IMEM_DEPTH   = 256;
   localparam int DMEM_DEPTH   = 256;
   localparam int HALT_TIMEOUT = 1000;
   localparam int DRAIN_CYCLES = 8;

   logic       clk;
   logic       arstN;
   logic       run;
   progWrite_t progWrite;
   retire_t    retire;
   logic       halted;
   logic       err;

   word_t   prog [$];
   int      seed = 62855;
   int      errCount = 0;
   int      testsRun = 0;
   int      testsPassed = 0;
   int      retireCount = 0;

   `include "isaModel.svh"

   pipeCore #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) i_pipeCore (
      .clk(clk), .arstN(arstN), .run(run), .progWrite(progWrite),
      .retire(retire), .halted(halted), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic word_t rFormat(opcode_t op, regIdx_t rd, regIdx_t rs, regIdx_t rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic word_t iFormat(opcode_t op, regIdx_t rd, regIdx_t rs, logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   // LBI and BEQZ carry an 8-bit immediate
   function automatic word_t bFormat(opcode_t op, regIdx_t rd, logic [7:0] imm);
      return {op, rd, 1'b0, imm};
   endfunction

   // outputs are sampled on the falling edge, away from the DUT updates
   always @(negedge clk) begin
      retire_t exp;
      if (retire.valid) begin
         retireCount++;
         assert (run) else begin
            $display("Error at %0t: retire while run is low", $time);
            errCount++;
         end
         if (expQ.size() == 0) begin
            $display("retire at %0t has no expected record (dest %0d data %h halt %b)",
                     $time, retire.dest, retire.data, retire.isHalt);
            errCount++;
         end else begin
            exp = expQ.pop_front();
            assert (retire == exp) else begin
               $display("Error at %0t: retire %0d %h %b %b, expected %0d %h %b %b",
                        $time, retire.dest, retire.data, retire.isHalt, retire.illegal,
                        exp.dest, exp.data, exp.isHalt, exp.illegal);
               errCount++;
            end
         end
      end
   end

   task automatic applyReset();
      @(posedge clk);
      arstN     <= 1'b0;
      run       <= 1'b0;
      progWrite <= '0;
      repeat (5) @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
      assert (!retire.valid && !halted && !err) else begin
         $display("Error at %0t: outputs not idle after reset", $time);
         errCount++;
      end
   endtask

   task automatic loadProgram();
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         progWrite.valid <= 1'b1;
         progWrite.addr  <= imemAddr_t'(i);
         progWrite.instr <= prog[i];
      end
      @(posedge clk);
      progWrite <= '0;
   endtask

   task automatic runUntilHalt();
      bit seen;
      seen = 1'b0;
      @(posedge clk);
      run <= 1'b1;
      for (int c = 0; c < HALT_TIMEOUT && !seen; c++) begin
         @(negedge clk);
         seen = halted;
      end
      if (!seen) begin
         $display("timeout: halted never rose within %0d cycles", HALT_TIMEOUT);
         errCount++;
      end
      // watch for anything retiring behind the HALT
      repeat (DRAIN_CYCLES) @(negedge clk);
      @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic runTest(string name, bit expectErr);
      word_t progArr [];
      int    errBefore;
      int    expCount;
      errBefore = errCount;
      applyReset();
      loadProgram();
      progArr = new[prog.size()];
      foreach (prog[i]) begin
         progArr[i] = prog[i];
      end
      runModel(progArr, DMEM_DEPTH);
      expCount    = expQ.size();
      retireCount = 0;
      runUntilHalt();
      assert (expQ.size() == 0) else begin
         $display("Error at %0t: %0d expected retires missing", $time, expQ.size());
         errCount++;
      end
      assert (retireCount == expCount) else begin
         $display("Error at %0t: %0d retires, expected %0d", $time, retireCount, expCount);
         errCount++;
      end
      assert (err == expectErr) else begin
         $display("Error at %0t: err is %b, expected %b", $time, err, expectErr);
         errCount++;
      end
      testsRun++;
      if (errCount == errBefore) begin
         testsPassed++;
         $display("test %0d %s: ok, %0d retires", testsRun, name, retireCount);
      end else begin
         $display("test %0d %s: failed, %0d errors", testsRun, name, errCount - errBefore);
      end
   endtask

   initial begin
      int        errBefore;
      logic [7:0] loopCount;
      arstN     = 1'b0;
      run       = 1'b0;
      progWrite = '0;

      // chained ALU ops hit memory, writeback and register file bypass
      prog = {};
      prog.push_back(bFormat(LBI, 3'd1, 8'($random(seed))));
      prog.push_back(bFormat(LBI, 3'd2, 8'($random(seed))));
      prog.push_back(rFormat(ADD, 3'd3, 3'd1, 3'd2));
      prog.push_back(rFormat(SUB, 3'd4, 3'd3, 3'd1));
      prog.push_back(rFormat(AND, 3'd5, 3'd4, 3'd3));
      prog.push_back(rFormat(XOR, 3'd6, 3'd5, 3'd4));
      prog.push_back(iFormat(ADDI, 3'd7, 3'd6, 6'($random(seed))));
      prog.push_back(rFormat(ADD, 3'd1, 3'd7, 3'd6));
      prog.push_back(iFormat(ADDI, 3'd2, 3'd1, 6'($random(seed))));
      prog.push_back(rFormat(XOR, 3'd3, 3'd2, 3'd7));
      prog.push_back({HALT, 12'h000});
      runTest("alu forwarding", 1'b0);

      // store then load then a dependent add, one stall expected
      prog = {};
      prog.push_back(bFormat(LBI, 3'd1, 8'd5));
      prog.push_back(bFormat(LBI, 3'd2, 8'($random(seed))));
      prog.push_back(iFormat(ST, 3'd2, 3'd1, 6'd3));
      prog.push_back(iFormat(LD, 3'd3, 3'd1, 6'd3));
      prog.push_back(rFormat(ADD, 3'd4, 3'd3, 3'd2));
      prog.push_back({HALT, 12'h000});
      runTest("store load use", 1'b0);

      prog = {};
      prog.push_back(bFormat(LBI, 3'd1, 8'd0));
      prog.push_back(bFormat(BEQZ, 3'd1, 8'd2));
      prog.push_back(bFormat(LBI, 3'd2, 8'h11));
      prog.push_back(bFormat(LBI, 3'd3, 8'h22));
      prog.push_back(bFormat(LBI, 3'd4, 8'd1));
      prog.push_back(bFormat(BEQZ, 3'd4, 8'd1));
      prog.push_back(bFormat(LBI, 3'd5, 8'h33));
      prog.push_back({HALT, 12'h000});
      runTest("branch taken and not taken", 1'b0);

      // r0 stays zero, so BEQZ r0 is the backward jump
      loopCount = 8'(3 + ($random(seed) & 5));
      prog = {};
      prog.push_back(bFormat(LBI, 3'd1, loopCount));
      prog.push_back(bFormat(LBI, 3'd2, 8'd0));
      prog.push_back(iFormat(ADDI, 3'd2, 3'd2, 6'd1));
      prog.push_back(iFormat(ADDI, 3'd1, 3'd1, 6'h3F));
      prog.push_back(bFormat(BEQZ, 3'd1, 8'd1));
      prog.push_back(bFormat(BEQZ, 3'd0, 8'hFC));
      prog.push_back({HALT, 12'h000});
      runTest("countdown loop", 1'b0);

      prog = {};
      prog.push_back(bFormat(LBI, 3'd1, 8'd7));
      prog.push_back(16'hF000 | 16'($random(seed) & 16'h0FFF));
      prog.push_back(rFormat(ADD, 3'd2, 3'd1, 3'd1));
      prog.push_back({HALT, 12'h000});
      runTest("illegal opcode", 1'b1);

      // idle core, program loaded but run never raised
      errBefore = errCount;
      applyReset();
      loadProgram();
      repeat (20) @(negedge clk);
      assert (!halted && !err) else begin
         $display("Error at %0t: flags set while the core is idle", $time);
         errCount++;
      end
      testsRun++;
      if (errCount == errBefore) begin
         testsPassed++;
         $display("test %0d reset and idle load: ok", testsRun);
      end else begin
         $display("test %0d reset and idle load: failed, %0d errors", testsRun,
                  errCount - errBefore);
      end

      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               testsRun, testsPassed, testsRun - testsPassed, errCount);
      if (errCount == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* pipeCore.f */
+incdir+include
src/cpuPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipeCore.sv
verification/pipeCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the pipeCore testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f pipeCore.f --top-module pipeCoreTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/VpipeCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
   exit 1
fi
exit 0
